/* verilog/ttc_pkg.sv */
// Shared definitions for the TTC control block
// Widths and vector types, LHC orbit length, L1A FIFO depth,
// TTC command codes, AXI4-Lite register map and response codes,
// and the write channel FSM states
`default_nettype none

package ttc_pkg;

  // --------------------------------------------------
  // Bunch crossing and counter widths
  // --------------------------------------------------
  localparam int bxn_w     = 12;    // Bunch numbers 0 to 3563
  localparam int lhc_cycle = 3564;  // Crossings per orbit
  typedef logic [bxn_w-1:0] bxn_t;

  localparam int cnt_w = 32;        // Orbit and bc0 counters
  typedef logic [cnt_w-1:0] cnt_t;

  localparam int evt_w = 20;        // L1A event number
  typedef logic [evt_w-1:0] evt_t;

  // --------------------------------------------------
  // TTC command codes, anything else is ignored
  // --------------------------------------------------
  typedef logic [3:0] cmd_t;
  localparam cmd_t cmd_bc0    = 4'd1;
  localparam cmd_t cmd_resync = 4'd2;
  localparam cmd_t cmd_l1a    = 4'd3;
  localparam cmd_t cmd_ec0    = 4'd4;

  localparam int l1a_fifo_depth = 8;  // Power of two, pointers wrap freely

  // --------------------------------------------------
  // AXI4-Lite register map
  // --------------------------------------------------
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  localparam axil_addr_t reg_offset  = 8'h00;  // Read and write
  localparam axil_addr_t reg_bxn     = 8'h04;
  localparam axil_addr_t reg_orbit   = 8'h08;
  localparam axil_addr_t reg_bx0_rxd = 8'h0C;
  localparam axil_addr_t reg_bx0_lcl = 8'h10;
  localparam axil_addr_t reg_status  = 8'h14;
  localparam axil_addr_t reg_l1a_pop = 8'h18;  // Read pops the FIFO head
  localparam axil_addr_t reg_event   = 8'h1C;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef enum logic [1:0] {
    wr_idle,     // Between transactions
    wr_collect,  // Waiting for address and data halves
    wr_respond   // Write done, bvalid up
  } axil_wr_state_t;

endpackage

`default_nettype wire

/* verilog/ttc_cmd_decoder.sv */
// TTC command decoder
// Turns valid command codes into registered single-cycle pulses
// and keeps the running L1A event number
`timescale 1ns/10ps
`default_nettype none

module ttc_cmd_decoder import ttc_pkg::*; (
  input  wire        clock,
  input  wire        bxn_preset,
  input  wire cmd_t  ttc_cmd,
  input  wire        ttc_cmd_valid,
  output logic       bc0,
  output logic       resync,
  output logic       l1a,
  output evt_t       event_number
);

  logic l1a_cmd;  // L1A code on the input this cycle
  logic ec0;      // Event counter reset pulse, kept local

  assign l1a_cmd = ttc_cmd_valid && (ttc_cmd == cmd_l1a);

  // --------------------------------------------------
  // Command pulses
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      bc0    <= 1'b0;
      resync <= 1'b0;
      l1a    <= 1'b0;
      ec0    <= 1'b0;
    end else begin
      bc0    <= ttc_cmd_valid && (ttc_cmd == cmd_bc0);
      resync <= ttc_cmd_valid && (ttc_cmd == cmd_resync);
      l1a    <= l1a_cmd;                                   // One cycle after the code
      ec0    <= ttc_cmd_valid && (ttc_cmd == cmd_ec0);
    end
  end

  // --------------------------------------------------
  // Event number
  // --------------------------------------------------
  // Advances on the same edge that raises l1a, so the new number is
  // already present while the pulse is high and the FIFO captures it.
  // A clear pulse together with a new L1A code restarts at one.
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      event_number <= '0;
    end else if (l1a_cmd) begin
      if (resync || ec0) event_number <= evt_t'(1);      // First L1A after the clear
      else               event_number <= event_number + 1'b1;
    end else if (resync || ec0) begin
      event_number <= '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/bx_counter.sv */
// Bunch crossing counter
// Offset limiter, hold until first bc0, modulo 3564 count,
// sticky sync error, received and local bc0 counters,
// saturating orbit counter
`timescale 1ns/10ps
`default_nettype none

module bx_counter import ttc_pkg::*; (
  input  wire        clock,
  input  wire        bxn_preset,
  input  wire        bc0,
  input  wire        resync,
  input  wire bxn_t  bxn_offset,
  output bxn_t       bxn,
  output cnt_t       orbit_count,
  output cnt_t       bx0_rxd_count,
  output cnt_t       bx0_lcl_count,
  output logic       bxn_sync_err,
  output logic       bx0_sync_err
);

  bxn_t bxn_offset_lim;  // Offset clipped into one orbit
  logic bxn_hold;        // Waiting for a bc0
  logic bxn_load;        // Reload the offset this cycle
  logic bxn_ovf;         // Last crossing of the orbit
  logic bxn_sync;        // Counter sits at the offset, local bc0 point
  logic bx0_local;       // Counter at zero while running
  logic orbit_max;       // Orbit counter saturated

  // --------------------------------------------------
  // Offset limiter
  // --------------------------------------------------
  // Offsets past the last crossing would never be reached
  always_ff @(posedge clock) begin
    if (bxn_offset > bxn_t'(lhc_cycle - 1)) bxn_offset_lim <= bxn_t'(lhc_cycle - 1);
    else                                     bxn_offset_lim <= bxn_offset;
  end

  // --------------------------------------------------
  // Hold and load
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (bxn_preset)  bxn_hold <= 1'b1;
    else if (bc0)    bxn_hold <= 1'b0;  // Release on any bc0
    else if (resync) bxn_hold <= 1'b1;  // Wait again for the next bc0
  end

  assign bxn_load = (bxn_hold || resync) && !bc0;
  assign bxn_ovf  = (bxn == bxn_t'(lhc_cycle - 1));

  // --------------------------------------------------
  // Bunch counter
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (bxn_preset)   bxn <= '0;
    else if (bxn_load) bxn <= bxn_offset_lim;  // Parked at the offset
    else if (bxn_ovf)  bxn <= '0;              // Orbit wrap
    else               bxn <= bxn + 1'b1;
  end

  // --------------------------------------------------
  // Synchronisation check
  // --------------------------------------------------
  assign bxn_sync  = (bxn == bxn_offset_lim);
  assign bx0_local = (bxn == '0) && !bxn_load;

  always_ff @(posedge clock) begin
    if (bxn_preset || bxn_load) begin
      bxn_sync_err <= 1'b0;
    end else if (bc0) begin
      bxn_sync_err <= bxn_sync_err || !bxn_sync;  // bc0 off the expected crossing
    end else if (bxn_sync) begin
      bxn_sync_err <= 1'b1;                       // Offset reached, no bc0 seen
    end
  end

  assign bx0_sync_err = bxn_sync_err || bxn_load;  // Also flags while parked

  // --------------------------------------------------
  // bc0 counters
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (bxn_preset || resync) begin
      bx0_rxd_count <= '0;
      bx0_lcl_count <= '0;
    end else begin
      if (bc0)       bx0_rxd_count <= bx0_rxd_count + 1'b1;  // Received from TTC
      if (bx0_local) bx0_lcl_count <= bx0_lcl_count + 1'b1;  // Own zero crossing
    end
  end

  // --------------------------------------------------
  // Orbit counter
  // --------------------------------------------------
  assign orbit_max = (orbit_count == '1);

  always_ff @(posedge clock) begin
    if (bxn_preset || resync) begin
      orbit_count <= '0;
    end else if (bxn_ovf && !bxn_load && !orbit_max) begin
      orbit_count <= orbit_count + 1'b1;  // One per wrap, sticks at all ones
    end
  end

endmodule

`default_nettype wire

/* verilog/l1a_bxn_fifo.sv */
// L1A header FIFO
// Eight entries of event number and bunch number taken at each L1A,
// popped by the register file, sticky overflow on a dropped L1A
`timescale 1ns/10ps
`default_nettype none

module l1a_bxn_fifo import ttc_pkg::*; (
  input  wire         clock,
  input  wire         bxn_preset,
  input  wire         l1a,
  input  wire bxn_t   bxn,
  input  wire evt_t   event_number,
  input  wire         pop,
  output axil_data_t  head,
  output logic        empty,
  output logic [3:0]  level,
  output logic        overflow
);

  axil_data_t mem [l1a_fifo_depth];                // Entry is {event, bxn}
  logic [$clog2(l1a_fifo_depth)-1:0] wr_ptr;
  logic [$clog2(l1a_fifo_depth)-1:0] rd_ptr;
  logic full;
  logic push;  // Accepted L1A
  logic pull;  // Accepted pop

  assign full  = (level == 4'(l1a_fifo_depth));
  assign empty = (level == '0);
  assign push  = l1a && !full;
  assign pull  = pop && !empty;

  assign head = mem[rd_ptr];  // Valid only while not empty

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (push) mem[wr_ptr] <= {event_number, bxn};  // Values present during the pulse
  end

  // --------------------------------------------------
  // Pointers, level, overflow
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      level    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth
      if (pull) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pull})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;       // Both or neither
      endcase
      if (l1a && full) overflow <= 1'b1;  // Held until reset
    end
  end

endmodule

`default_nettype wire

/* verilog/ttc_axil_regs.sv */
// AXI4-Lite register file for the TTC block
// Write FSM for the offset register, registered read mux over
// counters, status, event number and the L1A FIFO head,
// single-cycle FIFO pop on a read of the pop register
`timescale 1ns/10ps
`default_nettype none

module ttc_axil_regs import ttc_pkg::*; (
  input  wire              clock,
  input  wire              bxn_preset,
  // AXI4-Lite slave
  input  wire axil_addr_t  awaddr,
  input  wire              awvalid,
  output logic             awready,
  input  wire axil_data_t  wdata,
  input  wire [3:0]        wstrb,
  input  wire              wvalid,
  output logic             wready,
  output logic [1:0]       bresp,
  output logic             bvalid,
  input  wire              bready,
  input  wire axil_addr_t  araddr,
  input  wire              arvalid,
  output logic             arready,
  output axil_data_t       rdata,
  output logic [1:0]       rresp,
  output logic             rvalid,
  input  wire              rready,
  // Block side
  output bxn_t             bxn_offset,
  input  wire bxn_t        bxn,
  input  wire cnt_t        orbit_count,
  input  wire cnt_t        bx0_rxd_count,
  input  wire cnt_t        bx0_lcl_count,
  input  wire              bxn_sync_err,
  input  wire evt_t        event_number,
  input  wire axil_data_t  fifo_head,
  input  wire              fifo_empty,
  input  wire [3:0]        fifo_level,
  input  wire              fifo_overflow,
  output logic             fifo_pop
);

  axil_wr_state_t wr_state;
  axil_addr_t     awaddr_q;  // Captured write halves
  axil_data_t     wdata_q;
  logic [3:0]     wstrb_q;
  logic           aw_held;
  logic           w_held;
  axil_data_t     rd_mux;    // Read data for araddr

  function automatic logic is_mapped(input axil_addr_t addr);
    case (addr)
      reg_offset, reg_bxn, reg_orbit, reg_bx0_rxd,
      reg_bx0_lcl, reg_status, reg_l1a_pop, reg_event: is_mapped = 1'b1;
      default:                                          is_mapped = 1'b0;
    endcase
  endfunction

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      wr_state   <= wr_idle;
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      aw_held    <= 1'b0;
      w_held     <= 1'b0;
      bxn_offset <= '0;
    end else begin
      case (wr_state)
        wr_idle: begin
          awready  <= 1'b1;        // Open both halves
          wready   <= 1'b1;
          aw_held  <= 1'b0;
          w_held   <= 1'b0;
          wr_state <= wr_collect;
        end
        wr_collect: begin
          if (awvalid && awready) begin
            aw_held <= 1'b1;
            awready <= 1'b0;
          end
          if (wvalid && wready) begin
            w_held <= 1'b1;
            wready <= 1'b0;
          end
          if (aw_held && w_held) begin
            if (awaddr_q == reg_offset) begin  // Only writable register
              if (wstrb_q[0]) bxn_offset[7:0]  <= wdata_q[7:0];
              if (wstrb_q[1]) bxn_offset[11:8] <= wdata_q[11:8];
            end
            bvalid   <= 1'b1;
            wr_state <= wr_respond;
          end
        end
        wr_respond: begin
          if (bready) begin
            bvalid   <= 1'b0;
            wr_state <= wr_idle;
          end
        end
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // Write payload
  always_ff @(posedge clock) begin
    if (awvalid && awready) awaddr_q <= awaddr;
    if (wvalid && wready) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (wr_state == wr_collect && aw_held && w_held) begin
      bresp <= is_mapped(awaddr_q) ? resp_okay : resp_slverr;
    end
  end

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  always_comb begin
    case (araddr)
      reg_offset:  rd_mux = {20'b0, bxn_offset};
      reg_bxn:     rd_mux = {20'b0, bxn};
      reg_orbit:   rd_mux = orbit_count;
      reg_bx0_rxd: rd_mux = bx0_rxd_count;
      reg_bx0_lcl: rd_mux = bx0_lcl_count;
      reg_status:  rd_mux = {24'b0, fifo_level, 1'b0, fifo_overflow, fifo_empty, bxn_sync_err};
      reg_l1a_pop: rd_mux = fifo_empty ? '0 : fifo_head;  // Empty reads as zero
      reg_event:   rd_mux = {12'b0, event_number};
      default:     rd_mux = '0;                           // Unmapped
    endcase
  end

  always_ff @(posedge clock) begin
    if (bxn_preset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      fifo_pop <= 1'b0;
    end else begin
      fifo_pop <= 1'b0;  // Single cycle
      if (arready && arvalid) begin
        arready  <= 1'b0;
        rvalid   <= 1'b1;
        fifo_pop <= (araddr == reg_l1a_pop) && !fifo_empty;  // Head already in rdata
      end else if (rvalid) begin
        if (rready) begin  // Hold data until taken
          rvalid  <= 1'b0;
          arready <= 1'b1;
        end
      end else begin
        arready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (arready && arvalid) begin
      rdata <= rd_mux;
      rresp <= is_mapped(araddr) ? resp_okay : resp_slverr;
    end
  end

endmodule

`default_nettype wire

/* verilog/ttc_top.sv */
// TTC control block top level
// Command decoder, bunch crossing counter, L1A FIFO and
// AXI4-Lite register file, all on one clock
`timescale 1ns/10ps
`default_nettype none

module ttc_top import ttc_pkg::*; (
  input  wire              clock,
  input  wire              bxn_preset,
  input  wire cmd_t        ttc_cmd,
  input  wire              ttc_cmd_valid,
  input  wire axil_addr_t  awaddr,
  input  wire              awvalid,
  output wire              awready,
  input  wire axil_data_t  wdata,
  input  wire [3:0]        wstrb,
  input  wire              wvalid,
  output wire              wready,
  output wire [1:0]        bresp,
  output wire              bvalid,
  input  wire              bready,
  input  wire axil_addr_t  araddr,
  input  wire              arvalid,
  output wire              arready,
  output wire axil_data_t  rdata,
  output wire [1:0]        rresp,
  output wire              rvalid,
  input  wire              rready
);

  wire        bc0, resync, l1a;
  evt_t       event_number;
  bxn_t       bxn, bxn_offset;
  cnt_t       orbit_count, bx0_rxd_count, bx0_lcl_count;
  wire        bxn_sync_err;
  axil_data_t fifo_head;
  wire        fifo_empty, fifo_overflow, fifo_pop;
  wire [3:0]  fifo_level;

  ttc_cmd_decoder dec0 (
    .clock, .bxn_preset, .ttc_cmd, .ttc_cmd_valid,
    .bc0, .resync, .l1a, .event_number
  );

  // bx0_sync_err strobe has no register slot, left open
  bx_counter bxc0 (
    .clock, .bxn_preset, .bc0, .resync, .bxn_offset,
    .bxn, .orbit_count, .bx0_rxd_count, .bx0_lcl_count,
    .bxn_sync_err, .bx0_sync_err()
  );

  l1a_bxn_fifo fifo0 (
    .clock, .bxn_preset, .l1a, .bxn, .event_number, .pop(fifo_pop),
    .head(fifo_head), .empty(fifo_empty), .level(fifo_level), .overflow(fifo_overflow)
  );

  ttc_axil_regs regs0 (
    .clock, .bxn_preset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .bxn_offset, .bxn, .orbit_count, .bx0_rxd_count, .bx0_lcl_count,
    .bxn_sync_err, .event_number,
    .fifo_head, .fifo_empty, .fifo_level, .fifo_overflow, .fifo_pop
  );

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
// Testbench clock and reset source
// 100 ns clock period, bxn_preset held high for the first 10 cycles
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic bxn_preset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;  // 100 ns period
  end

  initial begin
    bxn_preset = 1'b1;
    repeat (10) @(posedge clock);
    @(negedge clock) bxn_preset = 1'b0;  // Released away from the active edge
  end

endmodule

`default_nettype wire

/* dv/ttc_tb.sv */
// Testbench for the TTC control block
// AXI4-Lite read and write tasks, TTC command driver, stimulus table,
// reference model of bunch number, event number and L1A FIFO, report
`timescale 1ns/10ps
`default_nettype none

module ttc_tb import ttc_pkg::*;;

  typedef enum logic [2:0] {
    act_write, act_cmd, act_idle, act_read, act_pop, act_resp, act_hold
  } act_t;

  typedef struct packed {
    act_t          act;
    logic [7:0]    test;
    logic [31:0]   arg;    // Data, command code, cycles or address
    logic [31:0]   exp;
    logic [31:0]   mask;
  } row_t;

  logic clock, bxn_preset;
  cmd_t ttc_cmd;
  logic ttc_cmd_valid;
  axil_addr_t awaddr, araddr;
  axil_data_t wdata, rdata;
  logic [3:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  row_t rows[$];
  logic [31:0] fifo_q[$];   // Expected FIFO entries
  integer seed = 63;
  integer cyc = 0;          // Posedge count
  integer errors = 0;
  integer passes = 0;
  integer bc0_cyc = 0;
  bxn_t lim = '0;           // Expected limited offset
  bxn_t base = '0;          // Offset in force at the releasing bc0
  logic held = 1'b1;        // Counter waiting for bc0
  evt_t ev = '0;

  clock_gen clk0 (.clock(clock), .bxn_preset(bxn_preset));

  ttc_top dut0 (
    .clock, .bxn_preset, .ttc_cmd, .ttc_cmd_valid,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  always @(posedge clock) cyc <= cyc + 1;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic add_row(input act_t act, input int test, input int arg,
                         input logic [31:0] exp, input logic [31:0] mask);
    rows.push_back({act, 8'(test), 32'(arg), exp, mask});
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors = errors + 1;
    end else begin
      passes = passes + 1;
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR at t=%0t: %s did not respond within 1000 cycles", $time, what);
    $display("checks passed %0d, failed %0d", passes, errors + 1);
    $display("test failed");
    $finish;
  endtask

  task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
    int n;
    logic aw_go, w_go;
    awaddr = addr;
    wdata = data;
    wstrb = 4'hF;
    awvalid = 1'b1;
    wvalid = 1'b1;
    n = 0;
    while (awvalid || wvalid) begin
      if (n++ > 1000) abort_run("write address or data channel");
      aw_go = awvalid && awready;  // Handshake on the coming edge
      w_go = wvalid && wready;
      @(negedge clock);
      if (aw_go) awvalid = 1'b0;
      if (w_go) wvalid = 1'b0;
    end
    bready = 1'b1;
    n = 0;
    while (!bvalid) begin
      if (n++ > 1000) abort_run("write response channel");
      @(negedge clock);
    end
    compare_value("bresp", 32'(bresp), 32'(resp_okay));
    @(negedge clock) bready = 1'b0;
  endtask

  // Read with rready held low for hold cycles after rvalid
  task automatic axi_read(input axil_addr_t addr, input int hold,
                          output axil_data_t data, output logic [1:0] resp);
    int n;
    logic go;
    araddr = addr;
    arvalid = 1'b1;
    n = 0;
    while (arvalid) begin
      if (n++ > 1000) abort_run("read address channel");
      go = arready;
      @(negedge clock);
      if (go) arvalid = 1'b0;
    end
    araddr = ~addr;  // Address bus moves on once accepted
    n = 0;
    while (!rvalid) begin
      if (n++ > 1000) abort_run("read data channel");
      @(negedge clock);
    end
    data = rdata;
    resp = rresp;
    repeat (hold) begin  // Back-pressure, data must not move
      @(negedge clock);
      compare_value("rvalid held", 32'(rvalid), 32'd1);
      compare_value("rdata held", rdata, data);
    end
    rready = 1'b1;
    @(negedge clock) rready = 1'b0;
  endtask

  // One-cycle command plus reference model update
  task automatic send_cmd(input cmd_t code);
    bxn_t b;
    ttc_cmd = code;
    ttc_cmd_valid = 1'b1;
    case (code)
      cmd_bc0: begin
        held = 1'b0;
        bc0_cyc = cyc;
        base = lim;
      end
      cmd_resync: begin
        held = 1'b1;
        ev = '0;
      end
      cmd_ec0: ev = '0;
      cmd_l1a: begin
        ev = ev + 1'b1;
        b = held ? lim : bxn_t'((32'(base) + 32'(cyc - bc0_cyc)) % lhc_cycle);
        if (fifo_q.size() < l1a_fifo_depth) fifo_q.push_back({ev, b});
      end
      default: ;
    endcase
    @(negedge clock);
    ttc_cmd_valid = 1'b0;
    ttc_cmd = '0;
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  task automatic build_table();
    // Test 1 held counter and offset limit
    add_row(act_write, 1, 200, 0, 0);
    add_row(act_idle, 1, 3, 0, 0);
    add_row(act_read, 1, reg_bxn, 200, 32'hFFF);
    add_row(act_idle, 1, 20, 0, 0);
    add_row(act_read, 1, reg_bxn, 200, 32'hFFF);
    add_row(act_write, 1, 4000, 0, 0);
    add_row(act_idle, 1, 3, 0, 0);
    add_row(act_read, 1, reg_bxn, 3563, 32'hFFF);
    add_row(act_read, 1, reg_offset, 4000, 32'hFFF);
    // Test 2 latched bunch and event numbers
    add_row(act_write, 2, 160, 0, 0);
    add_row(act_idle, 2, 3, 0, 0);
    add_row(act_cmd, 2, cmd_ec0, 0, 0);
    add_row(act_cmd, 2, cmd_bc0, 0, 0);
    for (int i = 0; i < 4; i++) begin
      add_row(act_idle, 2, 0, 0, 0);  // Random gap
      add_row(act_cmd, 2, cmd_l1a, 0, 0);
    end
    add_row(act_idle, 2, 3, 0, 0);
    add_row(act_read, 2, reg_event, 4, 32'hFFFF_FFFF);  // Fourth L1A since ec0
    for (int i = 0; i < 4; i++) add_row(act_pop, 2, 0, 0, 0);
    add_row(act_cmd, 2, cmd_ec0, 0, 0);
    add_row(act_cmd, 2, cmd_l1a, 0, 0);
    add_row(act_idle, 2, 3, 0, 0);
    add_row(act_pop, 2, 0, 0, 0);
    // Test 3 sync error
    add_row(act_cmd, 3, cmd_resync, 0, 0);
    add_row(act_idle, 3, 5, 0, 0);
    add_row(act_cmd, 3, cmd_bc0, 0, 0);
    add_row(act_idle, 3, lhc_cycle - 1, 0, 0);
    add_row(act_cmd, 3, cmd_bc0, 0, 0);
    add_row(act_idle, 3, 3, 0, 0);
    add_row(act_read, 3, reg_status, 0, 1);
    add_row(act_idle, 3, 100, 0, 0);
    add_row(act_cmd, 3, cmd_bc0, 0, 0);
    add_row(act_idle, 3, 3, 0, 0);
    add_row(act_read, 3, reg_status, 1, 1);
    add_row(act_cmd, 3, cmd_resync, 0, 0);
    add_row(act_cmd, 3, cmd_bc0, 0, 0);
    add_row(act_idle, 3, 3, 0, 0);
    add_row(act_read, 3, reg_status, 0, 1);
    // Test 4 bc0 counters and clear on resync
    add_row(act_cmd, 4, cmd_resync, 0, 0);
    for (int i = 0; i < 3; i++) begin
      add_row(act_cmd, 4, cmd_bc0, 0, 0);
      add_row(act_idle, 4, 10, 0, 0);
    end
    add_row(act_read, 4, reg_bx0_rxd, 3, 32'hFFFF_FFFF);
    add_row(act_idle, 4, 3500, 0, 0);  // Past the first wrap from offset 160
    add_row(act_read, 4, reg_orbit, 1, 32'hFFFF_FFFF);
    add_row(act_read, 4, reg_bx0_lcl, 1, 32'hFFFF_FFFF);
    add_row(act_cmd, 4, cmd_resync, 0, 0);
    add_row(act_idle, 4, 3, 0, 0);
    add_row(act_read, 4, reg_bx0_rxd, 0, 32'hFFFF_FFFF);
    add_row(act_read, 4, reg_orbit, 0, 32'hFFFF_FFFF);
    add_row(act_read, 4, reg_bx0_lcl, 0, 32'hFFFF_FFFF);
    // Test 5 FIFO overflow and drain
    add_row(act_cmd, 5, cmd_ec0, 0, 0);
    for (int i = 0; i < 9; i++) begin
      add_row(act_cmd, 5, cmd_l1a, 0, 0);
      add_row(act_idle, 5, 2, 0, 0);
    end
    add_row(act_read, 5, reg_status, 32'h84, 32'hF6);  // Level 8, overflow, not empty
    for (int i = 0; i < 9; i++) add_row(act_pop, 5, 0, 0, 0);
    add_row(act_read, 5, reg_status, 32'h2, 32'h2);
    // Test 6 error response and back-pressure
    add_row(act_resp, 6, 8'h40, resp_slverr, 0);
    add_row(act_hold, 6, reg_offset, 160, 32'hFFF);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    axil_data_t d;
    logic [1:0] r;
    int n;
    int cur;
    int test_err;
    ttc_cmd = '0;
    ttc_cmd_valid = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    build_table();
    n = 0;
    while (bxn_preset !== 1'b0) begin
      if (n++ > 1000) abort_run("reset release");
      @(negedge clock);
    end
    @(negedge clock);
    cur = 1;
    test_err = 0;
    foreach (rows[i]) begin
      if (int'(rows[i].test) != cur) begin
        $display("test %0d %s", cur, (errors == test_err) ? "ok" : "FAILED");
        cur = int'(rows[i].test);
        test_err = errors;
      end
      case (rows[i].act)
        act_write: begin
          axi_write(reg_offset, rows[i].arg);
          lim = (rows[i].arg > lhc_cycle - 1) ? bxn_t'(lhc_cycle - 1) : bxn_t'(rows[i].arg);
        end
        act_cmd: send_cmd(cmd_t'(rows[i].arg));
        act_idle: begin
          n = (rows[i].arg == 0) ? (($random(seed) & 31) + 1) : int'(rows[i].arg);
          repeat (n) @(negedge clock);
        end
        act_read: begin
          axi_read(axil_addr_t'(rows[i].arg), 0, d, r);
          compare_value("rresp", 32'(r), 32'(resp_okay));
          compare_value($sformatf("reg 0x%0h", rows[i].arg), d & rows[i].mask,
                        rows[i].exp & rows[i].mask);
        end
        act_pop: begin
          axi_read(reg_l1a_pop, 0, d, r);
          compare_value("l1a fifo head", d, (fifo_q.size() == 0) ? 32'd0 : fifo_q.pop_front());
        end
        act_resp: begin
          axi_read(axil_addr_t'(rows[i].arg), 0, d, r);
          compare_value("rresp", 32'(r), rows[i].exp);
          compare_value("rdata unmapped", d, 32'd0);
        end
        default: begin  // Held read
          axi_read(axil_addr_t'(rows[i].arg), 5, d, r);
          compare_value("rdata after hold", d & rows[i].mask, rows[i].exp & rows[i].mask);
        end
      endcase
    end
    $display("test %0d %s", cur, (errors == test_err) ? "ok" : "FAILED");
    $display("checks passed %0d, failed %0d", passes, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
verilog/ttc_pkg.sv
verilog/ttc_cmd_decoder.sv
verilog/bx_counter.sv
verilog/l1a_bxn_fifo.sv
verilog/ttc_axil_regs.sv
verilog/ttc_top.sv
dv/clock_gen.sv
dv/ttc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the TTC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module ttc_tb -o ttc_sim

./obj_dir/ttc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  exit 1
fi
exit 0
